//--- adder_pkg.sv
`default_nettype none

package adder_pkg;

   // width of one input feature, also the output width
   localparam int sample_w = 8;

   // guard bits so that sixteen full-scale samples cannot overflow the sum
   localparam int ext_w = 4;

   // width of every partial and final sum
   localparam int sum_w = sample_w + ext_w;

   // features presented per item
   localparam int num_inputs = 16;

   // operands summed by one adder in a tree level
   localparam int fan_in = 4;

   // right shift applied to the rectified sum before saturation
   localparam int out_shift = 2;

   // two tree levels plus the output stage
   localparam int pipe_latency = 3;

   // raw input feature and scaled output
   typedef logic signed [sample_w-1:0] sample_t;

   // widened sum word
   typedef logic signed [sum_w-1:0] sum_t;

   // largest positive sample, used when the scaled sum does not fit
   localparam sample_t sat_max = sample_t'((1 << (sample_w - 1)) - 1);

endpackage

`default_nettype wire

//--- multi_adder.sv
`timescale 1ns/1ps
`default_nettype none

// Sixteen-input signed adder tree with rectified, scaled and saturated output.
// Latency from an en_in strobe to the matching en_out strobe is three cycles
// and a new item may be accepted every cycle.
module multi_adder (
   input  logic               clk,
   input  logic               rst,
   input  adder_pkg::sample_t d_in [adder_pkg::num_inputs],
   input  logic               en_in,
   output adder_pkg::sample_t d_out,
   output logic               en_out
);

   // first level, four partial sums of four samples each
   adder_pkg::sum_t l16_d [4];
   logic            l16_en;

   // second level, the complete sum
   adder_pkg::sum_t l4_d [1];
   logic            l4_en;

   // 16 samples to 4 sums
   tree_level #(
      .elem_t (adder_pkg::sample_t),
      .groups (4)
   ) l16 (
      .clk    (clk),
      .rst    (rst),
      .d_in   (d_in),
      .en_in  (en_in),
      .d_out  (l16_d),
      .en_out (l16_en)
   );

   // 4 sums to 1 sum
   tree_level #(
      .elem_t (adder_pkg::sum_t),
      .groups (1)
   ) l4 (
      .clk    (clk),
      .rst    (rst),
      .d_in   (l16_d),
      .en_in  (l16_en),
      .d_out  (l4_d),
      .en_out (l4_en)
   );

   // rectify, shift and clamp into the output sample
   relu_saturate u_relu_sat (
      .clk    (clk),
      .rst    (rst),
      .d_in   (l4_d[0]),
      .en_in  (l4_en),
      .d_out  (d_out),
      .en_out (en_out)
   );

endmodule

`default_nettype wire

//--- multi_adder_chk.sv
`timescale 1ns/1ps
`default_nettype none

// timing and range properties of the adder tree top level
module multi_adder_chk (
   input logic               clk,
   input logic               rst,
   input logic               en_in,
   input logic               en_out,
   input adder_pkg::sample_t d_out
);

   // a strobe survives only if rst is low at each of the three stage edges
   a_strobe_latency : assert property (
      @(posedge clk)
      !$isunknown($past(rst, adder_pkg::pipe_latency)) |->
      (en_out == ($past(en_in, adder_pkg::pipe_latency) &&
                  !$past(rst, 3) && !$past(rst, 2) && !$past(rst, 1)))
   ) else $error("en_out does not follow en_in after the pipeline latency");

   // rectified output is never negative
   a_out_not_negative : assert property (
      @(posedge clk) en_out |-> !d_out[adder_pkg::sample_w-1]
   ) else $error("d_out negative while en_out is high");

   a_out_known : assert property (
      @(posedge clk) en_out |-> !$isunknown(d_out)
   ) else $error("d_out has unknown bits while en_out is high");

endmodule

`default_nettype wire

//--- relu_saturate.sv
`timescale 1ns/1ps
`default_nettype none

// Output stage: rectify, scale down and clamp to the sample range.
module relu_saturate (
   input  logic               clk,
   input  logic               rst,
   input  adder_pkg::sum_t    d_in,
   input  logic               en_in,
   output adder_pkg::sample_t d_out,
   output logic               en_out
);

   // rectified sum, never negative
   adder_pkg::sum_t    relu_val;

   // rectified sum after the right shift
   adder_pkg::sum_t    shifted;

   // set when the shifted value does not fit a positive sample
   logic               ovf;

   adder_pkg::sample_t result;

   // negative sums are clamped to zero
   always_comb begin
      if (d_in[adder_pkg::sum_w-1]) begin
         relu_val = '0;
      end else begin
         relu_val = d_in;
      end
   end

   // relu_val is non-negative here, so the shift is a plain floor divide
   assign shifted = relu_val >>> adder_pkg::out_shift;

   // any set bit at or above the sample sign position means the value is
   // at least 2**(sample_w-1) and has to saturate
   assign ovf = |shifted[adder_pkg::sum_w-1:adder_pkg::sample_w-1];

   always_comb begin
      if (ovf) begin
         result = adder_pkg::sat_max;
      end else begin
         result = shifted[adder_pkg::sample_w-1:0];
      end
   end

   always_ff @(posedge clk) begin
      d_out <= result;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         en_out <= 1'b0;
      end else begin
         en_out <= en_in;
      end
   end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the adder tree testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_multi_adder \
   --Mdir obj_dir -o sim_multi_adder \
   -f vlog.f

status=0
output=$(./obj_dir/sim_multi_adder 2>&1) || status=$?
echo "$output"

if grep -qx "TEST OK" <<< "$output"; then
   echo "simulation passed"
   exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// clock and synchronous reset for the testbench
module tb_clock #(
   parameter int half_period  = 10,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // release just after an edge so the release never races the DUT
   initial begin
      rst = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- tb_multi_adder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_multi_adder;

   // edges from the input strobe to the output strobe
   localparam int out_latency   = 3;
   localparam int drain_timeout = 40;
   localparam int reset_timeout = 20;

   logic               clk;
   logic               rst;
   adder_pkg::sample_t d_in [adder_pkg::num_inputs];
   logic               en_in;
   adder_pkg::sample_t d_out;
   logic               en_out;

   // item being built before it is driven
   adder_pkg::sample_t stim [adder_pkg::num_inputs];

   // expected results and the cycle each one is due in
   int exp_q [$];
   int due_q [$];

   int unsigned lcg_state;
   int          cyc;
   string       cur_test;

   tb_clock clkgen (
      .clk (clk),
      .rst (rst)
   );

   multi_adder dut (
      .clk    (clk),
      .rst    (rst),
      .d_in   (d_in),
      .en_in  (en_in),
      .d_out  (d_out),
      .en_out (en_out)
   );

   bind multi_adder multi_adder_chk chk (
      .clk    (clk),
      .rst    (rst),
      .en_in  (en_in),
      .en_out (en_out),
      .d_out  (d_out)
   );

   always @(posedge clk) cyc <= cyc + 1;

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 8;
   endfunction

   // exact sum, clamp below zero, floor divide by four, clamp at 127
   function automatic int expected_out(input adder_pkg::sample_t v [adder_pkg::num_inputs]);
      int s;
      s = 0;
      for (int i = 0; i < adder_pkg::num_inputs; i++) begin
         s = s + int'(v[i]);
      end
      if (s < 0) begin
         return 0;
      end else if ((s / 4) > int'(adder_pkg::sat_max)) begin
         return int'(adder_pkg::sat_max);
      end
      return s / 4;
   endfunction

   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_problem(input string msg);
      $display("%s in test %s", msg, cur_test);
      $display("TEST FAILED");
      $fatal(1, "%s", msg);
   endtask

   // every output strobe must match the oldest item in flight
   always @(negedge clk) begin : monitor
      int exp_val;
      int due;
      if (en_out === 1'b1) begin
         assert (exp_q.size() > 0)
            else report_problem("output strobe with no item in flight");
         exp_val = exp_q.pop_front();
         due = due_q.pop_front();
         assert (d_out === adder_pkg::sample_t'(exp_val))
            else report_mismatch("d_out", exp_val, int'(d_out));
         assert (cyc == due)
            else report_mismatch("strobe cycle", due, cyc);
      end
   end

   task automatic idle_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic fill_const(input adder_pkg::sample_t v);
      foreach (stim[i]) stim[i] = v;
   endtask

   // spread a non-negative total evenly over the inputs
   task automatic fill_sum(input int total);
      int base;
      int rem;
      base = total / adder_pkg::num_inputs;
      rem = total % adder_pkg::num_inputs;
      for (int i = 0; i < adder_pkg::num_inputs; i++) begin
         stim[i] = adder_pkg::sample_t'(base + ((i < rem) ? 1 : 0));
      end
   endtask

   task automatic fill_random();
      foreach (stim[i]) stim[i] = adder_pkg::sample_t'(lcg_next());
   endtask

   // called 1 ns after an edge and returns at the same point of the next cycle
   task automatic drive_item(input int exp_val);
      foreach (stim[i]) d_in[i] = stim[i];
      en_in = 1'b1;
      exp_q.push_back(exp_val);
      due_q.push_back(cyc + out_latency);
      idle_cycle();
      en_in = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() > 0 && n < drain_timeout) begin
         idle_cycle();
         n++;
      end
      assert (exp_q.size() == 0) else report_problem("timeout waiting for output strobes");
      // a stray strobe during these quiet cycles shows up in the monitor
      repeat (out_latency + 2) idle_cycle();
   endtask

   task automatic test_reset();
      int n;
      cur_test = "reset";
      @(posedge clk);
      #1;
      // this strobe is sampled while rst is high and must vanish
      fill_random();
      foreach (stim[i]) d_in[i] = stim[i];
      en_in = 1'b1;
      idle_cycle();
      en_in = 1'b0;
      n = 0;
      while (rst === 1'b1 && n < reset_timeout) begin
         @(negedge clk);
         assert (en_out === 1'b0) else report_problem("en_out high during reset");
         n++;
      end
      assert (rst === 1'b0) else report_problem("reset was never released");
      repeat (6) begin
         @(negedge clk);
         assert (en_out === 1'b0)
            else report_problem("en_out high after reset without a strobe");
      end
      idle_cycle();
   endtask

   task automatic test_single();
      cur_test = "single";
      fill_const(8'sd0);
      drive_item(0);
      wait_drain();
      fill_const(8'sd1);
      drive_item(4);
      wait_drain();
      // mixed signs adding up to 100
      fill_const(8'sd0);
      stim[0] = 8'sd100;
      stim[1] = -8'sd50;
      stim[2] = 8'sd25;
      stim[3] = 8'sd25;
      stim[4] = -8'sd7;
      stim[5] = 8'sd7;
      drive_item(25);
      wait_drain();
   endtask

   task automatic test_rectify();
      cur_test = "rectify";
      fill_const(-8'sd1);
      drive_item(0);
      fill_const(8'sh80);
      drive_item(0);
      fill_const(8'sd0);
      stim[3] = -8'sd1;
      drive_item(0);
      wait_drain();
   endtask

   task automatic test_saturation();
      cur_test = "saturation";
      fill_sum(507);
      drive_item(126);
      fill_sum(508);
      drive_item(127);
      fill_sum(511);
      drive_item(127);
      fill_sum(512);
      drive_item(127);
      fill_const(8'sd127);
      drive_item(127);
      wait_drain();
   endtask

   task automatic test_stream();
      cur_test = "stream";
      for (int n = 0; n < 24; n++) begin
         fill_random();
         drive_item(expected_out(stim));
      end
      wait_drain();
   endtask

   task automatic test_gapped();
      int gap;
      cur_test = "gapped";
      for (int n = 0; n < 16; n++) begin
         fill_random();
         drive_item(expected_out(stim));
         gap = 1 + int'(lcg_next() % 3);
         repeat (gap) idle_cycle();
      end
      wait_drain();
   endtask

   initial begin
      en_in = 1'b0;
      foreach (d_in[i]) d_in[i] = '0;
      foreach (stim[i]) stim[i] = '0;
      lcg_state = 69;
      cur_test = "init";
      test_reset();
      test_single();
      test_rectify();
      test_saturation();
      test_stream();
      test_gapped();
      if (exp_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("TEST FAILED");
         $fatal(1, "items still in flight at the end");
      end
   end

endmodule

`default_nettype wire

//--- tree_level.sv
`timescale 1ns/1ps
`default_nettype none

// One registered level of the adder tree.
// Every run of fan_in consecutive inputs is reduced to one sum word.
module tree_level #(
   parameter type elem_t = adder_pkg::sample_t,
   parameter int  groups = 1
) (
   input  logic              clk,
   input  logic              rst,
   input  elem_t             d_in [groups*adder_pkg::fan_in],
   input  logic              en_in,
   output adder_pkg::sum_t   d_out [groups],
   output logic              en_out
);

   localparam int n_elems = groups * adder_pkg::fan_in;
   localparam int elem_w  = $bits(elem_t);

   // inputs after sign extension to the sum width
   adder_pkg::sum_t ext [n_elems];

   // combinational group sums, registered below
   adder_pkg::sum_t grp_sum [groups];

   // an element wider than the sum word would lose its upper bits
   if (elem_w > adder_pkg::sum_w) begin : g_width_check
      $error("tree_level: element width %0d exceeds sum width %0d",
             elem_w, adder_pkg::sum_w);
   end

   if (groups < 1) begin : g_groups_check
      $error("tree_level: groups must be at least 1, got %0d", groups);
   end

   // elem_t is signed, so the cast replicates the sign bit into the guard bits
   for (genvar i = 0; i < n_elems; i++) begin : g_ext
      assign ext[i] = adder_pkg::sum_t'(d_in[i]);
   end

   // group g covers elements g*fan_in up to g*fan_in + fan_in - 1
   always_comb begin
      for (int g = 0; g < groups; g++) begin
         grp_sum[g] = '0;
         for (int k = 0; k < adder_pkg::fan_in; k++) begin
            grp_sum[g] = grp_sum[g] + ext[g*adder_pkg::fan_in + k];
         end
      end
   end

   // sums are only meaningful while en_out is high
   always_ff @(posedge clk) begin
      for (int g = 0; g < groups; g++) begin
         d_out[g] <= grp_sum[g];
      end
   end

   // strobe travels with the data, a strobe seen during reset is dropped
   always_ff @(posedge clk) begin
      if (rst) begin
         en_out <= 1'b0;
      end else begin
         en_out <= en_in;
      end
   end

endmodule

`default_nettype wire

//--- vlog.f
adder_pkg.sv
tree_level.sv
relu_saturate.sv
multi_adder.sv
tb_clock.sv
multi_adder_chk.sv
tb_multi_adder.sv
